// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := iir_filter_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/iir_filter_tb.sv ====
`timescale 1ns/1ps

module iir_filter_tb;
	import iir_pkg::*;

	localparam int NUM_CASES = 4;
	localparam int WAIT_LIMIT = 64;
	localparam int IDLE_CYCLES = 12;

	// one row of the stimulus table
	typedef struct packed {
		coef_set_t coefs;
		logic use_random;
	} case_t;

	logic clk;
	logic reset;
	logic start;
	logic iir_start;
	logic signed [SAMPLE_W-1:0] din;
	logic [COEF_W-1:0] params;
	logic signed [SAMPLE_W-1:0] dout;
	logic ready;
	logic iir_done;

	case_t cases [NUM_CASES];
	logic signed [SAMPLE_W-1:0] fixed_samples [BLOCK_LEN];

	// reference history, at rest at the start of each block
	longint mx1;
	longint mx2;
	longint my1;
	longint my2;

	iir_filter i_iir_filter (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.iir_start (iir_start),
		.din       (din),
		.params    (params),
		.dout      (dout),
		.ready     (ready),
		.iir_done  (iir_done)
	);

	always #50 clk = ~clk;

	task automatic abort_run(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_sample(input string name, input logic signed [SAMPLE_W-1:0] got,
		input logic signed [SAMPLE_W-1:0] expected);
		if (got !== expected)
		begin
			$display("[FAIL] time %0t: %s is %0d, expected %0d", $time, name, got, expected);
			abort_run("sample value mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("[FAIL] time %0t: %s is %b, expected %b", $time, name, got, expected);
			abort_run("control flag mismatch");
		end
	endtask

	task automatic model_clear();
		mx1 = 0;
		mx2 = 0;
		my1 = 0;
		my2 = 0;
	endtask

	// Q4.12 biquad, shift by 12, clamp to 16 bits, keep the upper byte
	task automatic model_step(input coef_set_t c, input logic signed [SAMPLE_W-1:0] x,
		output logic signed [SAMPLE_W-1:0] d);
		longint acc;
		longint s;
		logic signed [15:0] ys;
		acc = longint'($signed(c.a1)) * my1 + longint'($signed(c.a2)) * my2;
		acc = acc + longint'($signed(c.b0)) * longint'(x);
		acc = acc + longint'($signed(c.b1)) * mx1 + longint'($signed(c.b2)) * mx2;
		s = acc >>> 12;
		if (s > 32767)
			s = 32767;
		else if (s < -32768)
			s = -32768;
		ys = s[15:0];
		d = ys[15:8];
		mx2 = mx1;
		mx1 = longint'(x);
		my2 = my1;
		my1 = longint'(ys);
	endtask

	// a1 goes out with iir_start, the rest follow one per cycle
	task automatic load_block(input coef_set_t c);
		@(posedge clk);
		iir_start <= 1'b1;
		params <= c.a1;
		@(posedge clk);
		iir_start <= 1'b0;
		params <= c.a2;
		@(posedge clk);
		params <= c.b0;
		@(posedge clk);
		params <= c.b1;
		@(posedge clk);
		params <= c.b2;
		@(posedge clk);
		params <= '0;
	endtask

	// called at a falling edge with ready high
	task automatic send_sample(input logic signed [SAMPLE_W-1:0] x,
		input logic signed [SAMPLE_W-1:0] expected);
		logic signed [SAMPLE_W-1:0] prev;
		prev = dout;
		@(posedge clk);
		start <= 1'b1;
		din <= x;
		@(posedge clk);
		start <= 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_sample("dout", dout, prev);
		@(posedge clk);
		@(negedge clk);
		check_sample("dout", dout, expected);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (ready !== 1'b1)
		begin
			@(negedge clk);
			check_flag("iir_done", iir_done, 1'b0);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("timed out waiting for ready to rise");
		end
	endtask

	// done must be a single-cycle pulse while ready stays low
	task automatic wait_done();
		int n;
		n = 0;
		while (iir_done !== 1'b1)
		begin
			@(negedge clk);
			check_flag("ready", ready, 1'b0);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("timed out waiting for iir_done");
		end
		@(negedge clk);
		check_flag("iir_done", iir_done, 1'b0);
		check_flag("ready", ready, 1'b0);
	endtask

	// a strobe in idle must be ignored
	task automatic check_idle_strobe();
		logic signed [SAMPLE_W-1:0] prev;
		prev = dout;
		@(posedge clk);
		start <= 1'b1;
		din <= 8'sh55;
		@(posedge clk);
		start <= 1'b0;
		repeat (IDLE_CYCLES)
		begin
			@(negedge clk);
			check_flag("ready", ready, 1'b0);
			check_flag("iir_done", iir_done, 1'b0);
			check_sample("dout", dout, prev);
		end
	endtask

	initial
	begin
		logic [31:0] rnd;
		logic signed [SAMPLE_W-1:0] x;
		logic signed [SAMPLE_W-1:0] expected;
		int ci;
		int n;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		iir_start = 1'b0;
		din = '0;
		params = '0;
		rnd = $urandom(40);

		// identity, full set, saturating, second block with new values
		cases[0] = '{coefs: '{16'h0000, 16'h0000, 16'h1000, 16'h0000, 16'h0000}, use_random: 1'b0};
		cases[1] = '{coefs: '{16'h0C00, 16'hF800, 16'h6000, 16'h3000, 16'h2000}, use_random: 1'b1};
		cases[2] = '{coefs: '{16'h8000, 16'h0000, 16'h7FFF, 16'h7FFF, 16'h7FFF}, use_random: 1'b0};
		cases[3] = '{coefs: '{16'hF000, 16'h0400, 16'h2000, 16'hE000, 16'h1000}, use_random: 1'b1};
		fixed_samples = '{8'sh7F, 8'sh80, 8'sh64, 8'sh9C, 8'sh40, 8'shC0, 8'sh7F, 8'sh7F,
			8'sh7F, 8'sh7F, 8'sh80, 8'sh80, 8'sh80, 8'sh80, 8'sh01, 8'sh00};

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_flag("ready", ready, 1'b0);
		check_flag("iir_done", iir_done, 1'b0);
		check_sample("dout", dout, 8'sh00);

		for (ci = 0; ci < NUM_CASES; ci++)
		begin
			model_clear();
			load_block(cases[ci].coefs);
			@(negedge clk);
			check_flag("ready", ready, 1'b1);
			for (n = 0; n < BLOCK_LEN; n++)
			begin
				if (cases[ci].use_random)
				begin
					rnd = $urandom;
					x = rnd[7:0];
				end
				else
					x = fixed_samples[n];
				model_step(cases[ci].coefs, x, expected);
				send_sample(x, expected);
				if (n < BLOCK_LEN - 1)
					wait_ready();
				else
					wait_done();
			end
			check_idle_strobe();
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== build.f ====
design/iir_pkg.sv
design/iir_sequencer.sv
design/iir_mac.sv
design/iir_output.sv
design/iir_filter.sv
bench/iir_filter_tb.sv

// ==== design/iir_filter.sv ====
`timescale 1ns/1ps

module iir_filter (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic iir_start,
	input  logic signed [iir_pkg::SAMPLE_W-1:0] din,
	input  logic [iir_pkg::COEF_W-1:0] params,
	output logic signed [iir_pkg::SAMPLE_W-1:0] dout,
	output logic ready,
	output logic iir_done
);
	import iir_pkg::*;

	coef_set_t coefs;
	mac_op_t op;
	logic signed [STATE_W-1:0] y;
	logic result_valid;
	logic emit;
	logic block_begin;
	logic block_last;

	// decode
	iir_sequencer i_iir_sequencer (
		.clk         (clk),
		.reset       (reset),
		.iir_start   (iir_start),
		.start       (start),
		.params      (params),
		.din         (din),
		.block_last  (block_last),
		.coefs       (coefs),
		.op          (op),
		.ready       (ready),
		.emit        (emit),
		.block_begin (block_begin)
	);

	// execute
	iir_mac i_iir_mac (
		.clk          (clk),
		.reset        (reset),
		.coefs        (coefs),
		.op           (op),
		.y            (y),
		.result_valid (result_valid)
	);

	// result
	iir_output i_iir_output (
		.clk          (clk),
		.reset        (reset),
		.result_valid (result_valid),
		.emit         (emit),
		.block_begin  (block_begin),
		.y            (y),
		.dout         (dout),
		.block_last   (block_last),
		.iir_done     (iir_done)
	);

endmodule

// ==== design/iir_mac.sv ====
`timescale 1ns/1ps

module iir_mac (
	input  logic clk,
	input  logic reset,
	input  iir_pkg::coef_set_t coefs,
	input  iir_pkg::mac_op_t op,
	output logic signed [iir_pkg::STATE_W-1:0] y,
	output logic result_valid
);
	import iir_pkg::*;

	// input history
	logic signed [SAMPLE_W-1:0] x1;
	logic signed [SAMPLE_W-1:0] x2;

	// output history
	logic signed [STATE_W-1:0] y1;
	logic signed [STATE_W-1:0] y2;

	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] feedback_sum;
	logic signed [ACC_W-1:0] forward_sum;
	logic signed [ACC_W-1:0] acc_shift;
	logic [ACC_W-STATE_W:0] acc_top;
	logic signed [STATE_W-1:0] y_sat;

	// a1 and a2 carry their own sign, so both halves are added
	assign feedback_sum = coefs.a1 * y1 + coefs.a2 * y2;
	assign forward_sum = coefs.b0 * op.x + coefs.b1 * x1 + coefs.b2 * x2;

	always_ff @(posedge clk)
	begin
		case (op.step)
			step_feedback:
				acc <= feedback_sum;
			step_forward:
				acc <= acc + forward_sum;
			default:
			begin
			end
		endcase
	end

	// back to state scale, keeping the sign
	assign acc_shift = acc >>> FRAC_BITS;

	// sign bit of the state plus everything above it
	assign acc_top = acc_shift[ACC_W-1:STATE_W-1];

	always_comb
	begin
		if ((&acc_top) || !(|acc_top))
			y_sat = acc_shift[STATE_W-1:0];
		else if (acc_top[ACC_W-STATE_W])
			y_sat = {1'b1, {(STATE_W-1){1'b0}}};
		else
			y_sat = {1'b0, {(STATE_W-1){1'b1}}};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			x1 <= '0;
			x2 <= '0;
			y1 <= '0;
			y2 <= '0;
		end
		else
		begin
			case (op.step)
				step_clear:
				begin
					x1 <= '0;
					x2 <= '0;
					y1 <= '0;
					y2 <= '0;
				end
				step_sum:
				begin
					x2 <= x1;
					x1 <= op.x;
					y2 <= y1;
					y1 <= y_sat;
				end
				default:
				begin
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= (op.step == step_sum);
	end

	// newest output is the head of the history
	assign y = y1;

endmodule

// ==== design/iir_output.sv ====
`timescale 1ns/1ps

module iir_output (
	input  logic clk,
	input  logic reset,
	input  logic result_valid,
	input  logic emit,
	input  logic block_begin,
	input  logic signed [iir_pkg::STATE_W-1:0] y,
	output logic signed [iir_pkg::SAMPLE_W-1:0] dout,
	output logic block_last,
	output logic iir_done
);
	import iir_pkg::*;

	// samples emitted so far in this block
	logic [CNT_W-1:0] count;

	// block_last one cycle late, for edge detection
	logic last_q;

	// pins carry the upper byte of the state
	always_ff @(posedge clk)
	begin
		if (reset)
			dout <= '0;
		else if (result_valid)
			dout <= y[STATE_W-1 -: SAMPLE_W];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			count <= '0;
		else if (block_begin)
			count <= '0;
		else if (emit && count != CNT_W'(BLOCK_LEN))
			count <= count + 1'b1;
	end

	// includes the sample being emitted, so the sequencer sees it in emit
	assign block_last = (count == CNT_W'(BLOCK_LEN)) ||
		(emit && count == CNT_W'(BLOCK_LEN - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			last_q <= 1'b0;
			iir_done <= 1'b0;
		end
		else
		begin
			last_q <= block_last;
			iir_done <= block_last && !last_q;
		end
	end

endmodule

// ==== design/iir_pkg.sv ====
package iir_pkg;

	// sample width at the pins
	localparam int SAMPLE_W = 8;

	// coefficients are signed Q4.12
	localparam int COEF_W = 16;

	// stored output history y1, y2
	localparam int STATE_W = 16;

	// wide enough for two 16x16 products plus three 8x16 products
	localparam int ACC_W = 34;

	// shift from accumulator scale back to state scale
	localparam int FRAC_BITS = 12;

	// samples per block
	localparam int BLOCK_LEN = 16;

	// wait stage length after the sum step
	localparam int SETTLE_CYCLES = 4;

	// counter widths derived from the values above
	localparam int CNT_W = $clog2(BLOCK_LEN + 1);
	localparam int SETTLE_CNT_W = $clog2(SETTLE_CYCLES + 1);

	// sequencer states
	typedef enum logic [3:0] {
		st_idle,
		st_load_a2,
		st_load_b0,
		st_load_b1,
		st_load_b2,
		st_wait_sample,
		st_latch_sample,
		st_mac_feedback,
		st_mac_forward,
		st_mac_sum,
		st_settle,
		st_emit
	} seq_state_t;

	// one-cycle datapath commands
	typedef enum logic [2:0] {
		step_none,
		step_clear,
		step_feedback,
		step_forward,
		step_sum
	} mac_step_t;

	// coefficient set for one block
	typedef struct packed {
		logic signed [COEF_W-1:0] a1;
		logic signed [COEF_W-1:0] a2;
		logic signed [COEF_W-1:0] b0;
		logic signed [COEF_W-1:0] b1;
		logic signed [COEF_W-1:0] b2;
	} coef_set_t;

	// sample and command from sequencer to datapath
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] x;
		mac_step_t step;
	} mac_op_t;

endpackage

// ==== design/iir_sequencer.sv ====
`timescale 1ns/1ps

module iir_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic iir_start,
	input  logic start,
	input  logic [iir_pkg::COEF_W-1:0] params,
	input  logic signed [iir_pkg::SAMPLE_W-1:0] din,
	input  logic block_last,
	output iir_pkg::coef_set_t coefs,
	output iir_pkg::mac_op_t op,
	output logic ready,
	output logic emit,
	output logic block_begin
);
	import iir_pkg::*;

	seq_state_t state;
	seq_state_t state_next;

	// sample currently in flight
	logic signed [SAMPLE_W-1:0] x_q;

	// counts down through the settle stage
	logic [SETTLE_CNT_W-1:0] settle_cnt;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
			begin
				if (iir_start)
					state_next = st_load_a2;
			end
			st_load_a2:
				state_next = st_load_b0;
			st_load_b0:
				state_next = st_load_b1;
			st_load_b1:
				state_next = st_load_b2;
			st_load_b2:
				state_next = st_wait_sample;
			st_wait_sample:
			begin
				if (start)
					state_next = st_latch_sample;
			end
			st_latch_sample:
				state_next = st_mac_feedback;
			st_mac_feedback:
				state_next = st_mac_forward;
			st_mac_forward:
				state_next = st_mac_sum;
			st_mac_sum:
				state_next = st_settle;
			st_settle:
			begin
				if (settle_cnt == '0)
					state_next = st_emit;
			end
			st_emit:
			begin
				// block_last already counts the sample being emitted
				if (block_last)
					state_next = st_idle;
				else
					state_next = st_wait_sample;
			end
			default:
				state_next = st_idle;
		endcase
	end

	// a1 arrives with iir_start, then one coefficient per cycle
	always_ff @(posedge clk)
	begin
		case (state)
			st_idle:
			begin
				if (iir_start)
					coefs.a1 <= params;
			end
			st_load_a2:
				coefs.a2 <= params;
			st_load_b0:
				coefs.b0 <= params;
			st_load_b1:
				coefs.b1 <= params;
			st_load_b2:
				coefs.b2 <= params;
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (state == st_wait_sample && start)
			x_q <= din;
	end

	// loaded on the sum step, so settle lasts SETTLE_CYCLES + 1 cycles
	always_ff @(posedge clk)
	begin
		if (reset)
			settle_cnt <= '0;
		else if (state == st_mac_sum)
			settle_cnt <= SETTLE_CNT_W'(SETTLE_CYCLES);
		else if (state == st_settle && settle_cnt != '0)
			settle_cnt <= settle_cnt - 1'b1;
	end

	always_comb
	begin
		op.x = x_q;
		op.step = step_none;
		case (state)
			st_idle:
			begin
				// history is wiped at the start of every block
				if (iir_start)
					op.step = step_clear;
			end
			st_mac_feedback:
				op.step = step_feedback;
			st_mac_forward:
				op.step = step_forward;
			st_mac_sum:
				op.step = step_sum;
			default:
				op.step = step_none;
		endcase
	end

	assign ready = (state == st_wait_sample);
	assign emit = (state == st_emit);
	assign block_begin = (state == st_idle) && iir_start;

endmodule
